//--- src.f
+incdir+hdl
+incdir+bench
hdl/lz_sym_pkg.sv
hdl/lz_stat_pkg.sv
hdl/lz_sym_holder.sv
hdl/lz_cmd_issue.sv
hdl/lz_copy_tracker.sv
hdl/lz_frame_ctrl.sv
hdl/lz_ptr_histogram.sv
hdl/lz_expander_top.sv
bench/tb_lz_expander.sv

//--- bench/tb_lz_checks.svh
`ifndef TB_LZ_CHECKS_SVH
`define TB_LZ_CHECKS_SVH

   // ########################################
   // Compare tasks for each kind of result

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("Fail at time %0t: %s is %b, expected %b", $time, name, act, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input logic [`LZ_POS_W-1:0] act,
                              input logic [`LZ_POS_W-1:0] exp);
      if (act !== exp) begin
         $display("Fail at time %0t: %s is %0d, expected %0d", $time, name, act, exp);
         abort_run();
      end
   endtask

   task automatic check_literal(input logic [2:0] exp_num, input logic [31:0] exp_data);
      check_flag("ep_bm_lit_valid", ep_bm_lit_valid, 1'b1);
      check_flag("ep_bm_copy_valid", ep_bm_copy_valid, 1'b0);
      if (ep_bm_num_lit !== exp_num) begin
         $display("Fail at time %0t: ep_bm_num_lit is %0d, expected %0d",
                  $time, ep_bm_num_lit, exp_num);
         abort_run();
      end
      if (ep_bm_lit_data !== exp_data) begin
         $display("Fail at time %0t: ep_bm_lit_data is %h, expected %h",
                  $time, ep_bm_lit_data, exp_data);
         abort_run();
      end
   endtask

   task automatic check_copy(input logic [`LZ_COPY_OFF_W-1:0] exp_off,
                             input logic [`LZ_LEN_W-1:0] exp_len);
      check_flag("ep_bm_copy_valid", ep_bm_copy_valid, 1'b1);
      check_flag("ep_bm_lit_valid", ep_bm_lit_valid, 1'b0);
      if (ep_bm_copy_offset !== exp_off) begin
         $display("Fail at time %0t: ep_bm_copy_offset is %0d, expected %0d",
                  $time, ep_bm_copy_offset, exp_off);
         abort_run();
      end
      if (ep_bm_copy_length !== exp_len) begin
         $display("Fail at time %0t: ep_bm_copy_length is %0d, expected %0d",
                  $time, ep_bm_copy_length, exp_len);
         abort_run();
      end
   endtask

   task automatic check_frame_end(input lz_err_code_e exp_code);
      check_flag("ep_bm_eof", ep_bm_eof, 1'b1);
      if (ep_bm_eof_err_code !== exp_code) begin
         $display("Fail at time %0t: ep_bm_eof_err_code is %h, expected %h",
                  $time, ep_bm_eof_err_code, exp_code);
         abort_run();
      end
   endtask

   task automatic check_bins(input lz_ptr_bins_t exp_stb);
      if (ptr_len_stb !== exp_stb) begin
         $display("Fail at time %0t: ptr_len_stb is %b, expected %b",
                  $time, ptr_len_stb, exp_stb);
         abort_run();
      end
   endtask

`endif

//--- bench/tb_lz_expander.sv
`default_nettype none

`include "lz_defines.svh"

module tb_lz_expander
   import lz_sym_pkg::*;
   import lz_stat_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 4;
   localparam int TEST_CYCLES  = 20 + 10 + 30 + 25 + 35 + 80;   // Tests 1 to 6 in order
   localparam int SLACK_CYCLES = 100;

   logic                        clk;
   logic                        rst_n;
   lz_sym_t                     if_ep_sym;
   logic                        if_ep_sym_valid;
   logic                        bm_ep_pause;
   logic                        pl_ep_prefix_load;
   logic [`LZ_POS_W-1:0]        pl_ep_prefix_cnt;
   logic                        pl_ep_trace_bit;
   logic                        ep_bm_lit_valid;
   logic [2:0]                  ep_bm_num_lit;
   logic [31:0]                 ep_bm_lit_data;
   logic                        ep_bm_copy_valid;
   logic [`LZ_COPY_OFF_W-1:0]   ep_bm_copy_offset;
   logic [`LZ_LEN_W-1:0]        ep_bm_copy_length;
   logic                        ep_bm_eof;
   lz_err_code_e                ep_bm_eof_err_code;
   logic                        ep_bm_eob;
   logic                        ep_if_entry_done;
   lz_ptr_bins_t                ptr_len_stb;
   logic [`LZ_POS_W-1:0]        lz_bytes_decomp;
   logic [`LZ_POS_W-1:0]        lz_local_bytes;

   logic                        pause_req;   // Applied to bm_ep_pause at the next rising edge
   integer                      seed = 48586;

   task automatic abort_run();
      $display("Regression failed");
      $fatal(1, "Run stopped at the first error");
   endtask

`include "tb_lz_checks.svh"

   lz_expander_top uut (
      .clk                (clk),
      .rst_n              (rst_n),
      .if_ep_sym          (if_ep_sym),
      .if_ep_sym_valid    (if_ep_sym_valid),
      .bm_ep_pause        (bm_ep_pause),
      .pl_ep_prefix_load  (pl_ep_prefix_load),
      .pl_ep_prefix_cnt   (pl_ep_prefix_cnt),
      .pl_ep_trace_bit    (pl_ep_trace_bit),
      .ep_bm_lit_valid    (ep_bm_lit_valid),
      .ep_bm_num_lit      (ep_bm_num_lit),
      .ep_bm_lit_data     (ep_bm_lit_data),
      .ep_bm_copy_valid   (ep_bm_copy_valid),
      .ep_bm_copy_offset  (ep_bm_copy_offset),
      .ep_bm_copy_length  (ep_bm_copy_length),
      .ep_bm_eof          (ep_bm_eof),
      .ep_bm_eof_err_code (ep_bm_eof_err_code),
      .ep_bm_eob          (ep_bm_eob),
      .ep_if_entry_done   (ep_if_entry_done),
      .ptr_len_stb        (ptr_len_stb),
      .lz_bytes_decomp    (lz_bytes_decomp),
      .lz_local_bytes     (lz_local_bytes)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(CLK_PERIOD * (TEST_CYCLES + SLACK_CYCLES));
      $display("Timeout after %0d cycles, the tests did not finish",
               TEST_CYCLES + SLACK_CYCLES);
      abort_run();
   end

   // An end pulse must never share a cycle with a command
   always @(negedge clk) begin
      if (rst_n && (ep_bm_eof || ep_bm_eob) && (ep_bm_lit_valid || ep_bm_copy_valid)) begin
         $display("At time %0t an end of block or frame came out together with a command",
                  $time);
         abort_run();
      end
   end

   // ########################################
   // Stimulus, every task returns on a falling edge

   function automatic lz_sym_t symbol(input lz_sym_kind_e kind, input logic [2:0] cnt,
                                      input logic [31:0] data);
      lz_sym_t s;
      s           = '0;
      s.lit_valid = (kind == SYM_LIT);
      s.ptr_valid = (kind == SYM_PTR);
      s.eof_valid = (kind == SYM_EOF);
      s.eob_valid = (kind == SYM_EOB);
      s.lit_cnt   = cnt;
      s.data      = data;
      return s;
   endfunction

   function automatic lz_ptr_bins_t one_bin(input lz_ptr_bin_e b);
      lz_ptr_bins_t m;
      m    = '0;
      m[b] = 1'b1;
      return m;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      if_ep_sym_valid   <= 1'b0;
      pl_ep_prefix_load <= 1'b0;
      bm_ep_pause       <= pause_req;
      @(negedge clk);
   endtask

   task automatic send(input lz_sym_t s);
      @(posedge clk);
      if_ep_sym         <= s;
      if_ep_sym_valid   <= 1'b1;
      pl_ep_prefix_load <= 1'b0;
      bm_ep_pause       <= pause_req;
      @(negedge clk);
   endtask

   task automatic load_prefix(input logic [`LZ_POS_W-1:0] cnt, input logic trace);
      @(posedge clk);
      if_ep_sym_valid   <= 1'b0;
      pl_ep_prefix_load <= 1'b1;
      pl_ep_prefix_cnt  <= cnt;
      pl_ep_trace_bit   <= trace;
      bm_ep_pause       <= pause_req;
      @(negedge clk);
      next_cycle();
   endtask

   task automatic wait_entry_done(input int limit);
      int n;
      n = 0;
      do begin
         next_cycle();
         n++;
      end while (!ep_if_entry_done && n < limit);
      if (!ep_if_entry_done) begin
         $display("ep_if_entry_done did not return within %0d cycles", limit);
         abort_run();
      end
   endtask

   task automatic wait_end_pulse(input logic want_eof, input int limit);
      int   n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < limit) begin
         next_cycle();
         n++;
         seen = want_eof ? ep_bm_eof : ep_bm_eob;
      end
      if (!seen) begin
         $display("No end of %s pulse within %0d cycles", want_eof ? "frame" : "block", limit);
         abort_run();
      end
   endtask

   // ########################################
   // Directed tests

   task automatic literal_stream();
      logic [2:0]  cnt;
      logic [31:0] data;
      int          total;
      total = 0;
      load_prefix(`LZ_POS_W'(100), 1'b0);
      repeat (4) begin
         cnt  = 3'($unsigned($random(seed)) % 4 + 1);
         data = $random(seed);
         send(symbol(SYM_LIT, cnt, data));
         next_cycle();
         check_flag("ep_bm_lit_valid", ep_bm_lit_valid, 1'b0);
         check_flag("ep_if_entry_done", ep_if_entry_done, 1'b1);
         next_cycle();
         check_literal(cnt, data);
         total += cnt;
      end
      check_count("lz_bytes_decomp", lz_bytes_decomp, `LZ_POS_W'(100 + total));
      check_count("lz_local_bytes", lz_local_bytes, `LZ_POS_W'(total));
   endtask

   task automatic window_pointer();
      send(symbol(SYM_PTR, 3'd0, {16'd12, 16'd8}));
      next_cycle();
      check_flag("ep_bm_copy_valid", ep_bm_copy_valid, 1'b0);
      next_cycle();
      check_copy(12, 8);
      send(symbol(SYM_PTR, 3'd0, {16'd16, 16'd5}));   // Last offset inside the window
      next_cycle();
      next_cycle();
      check_copy(16, 5);
   endtask

   task automatic far_pointer();
      send(symbol(SYM_PTR, 3'd0, {16'd20, 16'd6}));
      next_cycle();
      next_cycle();
      check_copy(0, 6);
      send(symbol(SYM_EOF, 3'd0, 32'd0));
      wait_end_pulse(1'b1, 8);
      check_frame_end(ERR_SOFT_OFLOW);
      // Offset fits the window but runs ahead of the bytes produced
      load_prefix(`LZ_POS_W'(4), 1'b0);
      send(symbol(SYM_PTR, 3'd0, {16'd8, 16'd4}));
      next_cycle();
      next_cycle();
      check_copy(0, 4);
      send(symbol(SYM_EOF, 3'd0, 32'h0000_0055));
      wait_end_pulse(1'b1, 8);
      check_frame_end(lz_err_code_e'(32'h0000_0055));
   endtask

   task automatic paused_long_copy();
      int          copy_len;
      int          pause_cycles;
      int          busy_cycles;
      int          cyc;
      logic [31:0] data;
      copy_len     = 50;
      pause_cycles = 3;
      busy_cycles  = (copy_len + `LZ_BEAT_BYTES - 1) / `LZ_BEAT_BYTES - 1 + pause_cycles;
      data         = $random(seed);
      load_prefix(`LZ_POS_W'(200), 1'b0);
      send(symbol(SYM_PTR, 3'd0, {16'd16, 16'(copy_len)}));
      next_cycle();
      check_flag("ep_if_entry_done", ep_if_entry_done, 1'b1);   // From the pointer's own cycle
      pause_req = 1'b1;
      send(symbol(SYM_LIT, 3'd4, data));
      check_copy(16, copy_len);
      check_flag("ep_if_entry_done", ep_if_entry_done, 1'b0);
      cyc = 2;
      while (!ep_if_entry_done && cyc < busy_cycles + 4) begin
         if (cyc == 1 + pause_cycles) begin
            pause_req = 1'b0;
         end
         next_cycle();
         cyc++;
         check_flag("ep_bm_lit_valid", ep_bm_lit_valid, 1'b0);
      end
      check_count("cycles to ep_if_entry_done", `LZ_POS_W'(cyc), `LZ_POS_W'(busy_cycles + 2));
      next_cycle();
      check_literal(3'd4, data);
   endtask

   task automatic block_and_frame_end();
      logic [31:0] data;
      data = $random(seed);
      send(symbol(SYM_LIT, 3'd2, data));
      next_cycle();
      send(symbol(SYM_EOB, 3'd0, 32'd0));
      check_literal(3'd2, data);
      check_flag("ep_bm_eob", ep_bm_eob, 1'b0);
      wait_end_pulse(1'b0, 8);
      wait_entry_done(8);
      data = $random(seed);
      send(symbol(SYM_LIT, 3'd3, data));
      next_cycle();
      send(symbol(SYM_EOF, 3'd0, 32'd0));
      check_literal(3'd3, data);
      check_flag("ep_bm_eof", ep_bm_eof, 1'b0);
      wait_end_pulse(1'b1, 8);
      check_frame_end(ERR_NONE);
      send(symbol(SYM_LIT, 3'd1, $random(seed)));   // Disarmed, so it is dropped
      repeat (4) begin
         next_cycle();
         check_flag("ep_bm_lit_valid", ep_bm_lit_valid, 1'b0);
         check_flag("ep_if_entry_done", ep_if_entry_done, 1'b0);
      end
      check_count("lz_bytes_decomp", lz_bytes_decomp, '0);
   endtask

   task automatic length_histogram();
      logic [15:0]  lens [5];
      lz_ptr_bins_t exp_stb [5];
      int           i;
      lens    = '{16'd3, 16'd10, 16'd20, 16'd300, 16'd2};
      exp_stb = '{one_bin(BIN_LEN_3), one_bin(BIN_LEN_10), one_bin(BIN_LEN_11_31),
                  one_bin(BIN_LEN_256), lz_ptr_bins_t'(0)};
      load_prefix(`LZ_POS_W'(1000), 1'b1);
      for (i = 0; i < 5; i++) begin
         send(symbol(SYM_PTR, 3'd0, {16'd4, lens[i]}));
         next_cycle();
         check_bins(exp_stb[i]);
         wait_entry_done(30);
      end
      load_prefix(`LZ_POS_W'(64), 1'b0);
      for (i = 0; i < 4; i += 3) begin
         send(symbol(SYM_PTR, 3'd0, {16'd4, lens[i]}));
         next_cycle();
         check_bins('0);
         wait_entry_done(30);
      end
   endtask

   initial begin
      rst_n             = 1'b0;
      if_ep_sym         = '0;
      if_ep_sym_valid   = 1'b0;
      bm_ep_pause       = 1'b0;
      pl_ep_prefix_load = 1'b0;
      pl_ep_prefix_cnt  = '0;
      pl_ep_trace_bit   = 1'b0;
      pause_req         = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_flag("ep_bm_lit_valid", ep_bm_lit_valid, 1'b0);
      check_flag("ep_bm_copy_valid", ep_bm_copy_valid, 1'b0);
      check_flag("ep_if_entry_done", ep_if_entry_done, 1'b0);
      check_bins('0);

      literal_stream();
      window_pointer();
      far_pointer();
      paused_long_copy();
      block_and_frame_end();
      length_histogram();

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/lz_expander_top.sv
`default_nettype none

`include "lz_defines.svh"

module lz_expander_top
   import lz_sym_pkg::*;
   import lz_stat_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire lz_sym_t                if_ep_sym,
   input  wire logic                   if_ep_sym_valid,
   input  wire logic                   bm_ep_pause,
   input  wire logic                   pl_ep_prefix_load,
   input  wire logic [`LZ_POS_W-1:0]   pl_ep_prefix_cnt,
   input  wire logic                   pl_ep_trace_bit,
   output logic                        ep_bm_lit_valid,
   output logic [2:0]                  ep_bm_num_lit,
   output logic [31:0]                 ep_bm_lit_data,
   output logic                        ep_bm_copy_valid,
   output logic [`LZ_COPY_OFF_W-1:0]   ep_bm_copy_offset,
   output logic [`LZ_LEN_W-1:0]        ep_bm_copy_length,
   output logic                        ep_bm_eof,
   output lz_err_code_e                ep_bm_eof_err_code,
   output logic                        ep_bm_eob,
   output logic                        ep_if_entry_done,
   output lz_ptr_bins_t                ptr_len_stb,
   output logic [`LZ_POS_W-1:0]        lz_bytes_decomp,
   output logic [`LZ_POS_W-1:0]        lz_local_bytes
);

   lz_sym_kind_e           sym_kind;
   logic [31:0]            sym_data;
   logic [2:0]             lit_cnt;
   logic                   copy_busy;
   logic                   copy_start;
   logic [`LZ_LEN_W-1:0]   copy_len;
   logic [`LZ_POS_W-1:0]   cur_pos;
   logic                   offset_err;
   logic [`LZ_LEN_W-1:0]   cmd_bytes;
   logic                   out_busy;
   logic                   armed;
   logic                   frame_end;

   lz_sym_holder u_holder (
      .clk              (clk),
      .rst_n            (rst_n),
      .if_ep_sym        (if_ep_sym),
      .if_ep_sym_valid  (if_ep_sym_valid),
      .bm_ep_pause      (bm_ep_pause),
      .copy_busy        (copy_busy),
      .armed            (armed),
      .frame_end        (frame_end),
      .sym_kind         (sym_kind),
      .sym_data         (sym_data),
      .lit_cnt          (lit_cnt),
      .ep_if_entry_done (ep_if_entry_done)
   );

   lz_cmd_issue u_issue (
      .clk               (clk),
      .rst_n             (rst_n),
      .sym_kind          (sym_kind),
      .sym_data          (sym_data),
      .lit_cnt           (lit_cnt),
      .cur_pos           (cur_pos),
      .ep_bm_lit_valid   (ep_bm_lit_valid),
      .ep_bm_num_lit     (ep_bm_num_lit),
      .ep_bm_lit_data    (ep_bm_lit_data),
      .ep_bm_copy_valid  (ep_bm_copy_valid),
      .ep_bm_copy_offset (ep_bm_copy_offset),
      .ep_bm_copy_length (ep_bm_copy_length),
      .copy_start        (copy_start),
      .copy_len          (copy_len),
      .offset_err        (offset_err),
      .cmd_bytes         (cmd_bytes),
      .out_busy          (out_busy)
   );

   lz_copy_tracker u_tracker (
      .clk         (clk),
      .rst_n       (rst_n),
      .copy_start  (copy_start),
      .copy_len    (copy_len),
      .bm_ep_pause (bm_ep_pause),
      .frame_end   (frame_end),
      .copy_busy   (copy_busy)
   );

   lz_frame_ctrl u_frame (
      .clk                (clk),
      .rst_n              (rst_n),
      .sym_kind           (sym_kind),
      .sym_data           (sym_data),
      .cmd_bytes          (cmd_bytes),
      .offset_err         (offset_err),
      .out_busy           (out_busy),
      .pl_ep_prefix_load  (pl_ep_prefix_load),
      .pl_ep_prefix_cnt   (pl_ep_prefix_cnt),
      .cur_pos            (cur_pos),
      .armed              (armed),
      .frame_end          (frame_end),
      .ep_bm_eob          (ep_bm_eob),
      .ep_bm_eof          (ep_bm_eof),
      .ep_bm_eof_err_code (ep_bm_eof_err_code),
      .lz_bytes_decomp    (lz_bytes_decomp),
      .lz_local_bytes     (lz_local_bytes)
   );

   lz_ptr_histogram u_hist (
      .clk               (clk),
      .rst_n             (rst_n),
      .sym_kind          (sym_kind),
      .sym_data          (sym_data),
      .pl_ep_prefix_load (pl_ep_prefix_load),
      .pl_ep_trace_bit   (pl_ep_trace_bit),
      .ptr_len_stb       (ptr_len_stb)
   );

endmodule

`default_nettype wire

//--- hdl/lz_ptr_histogram.sv
`default_nettype none

`include "lz_defines.svh"

module lz_ptr_histogram
   import lz_sym_pkg::*;
   import lz_stat_pkg::*;
(
   input  wire logic           clk,
   input  wire logic           rst_n,
   input  wire lz_sym_kind_e   sym_kind,
   input  wire logic [31:0]    sym_data,
   input  wire logic           pl_ep_prefix_load,
   input  wire logic           pl_ep_trace_bit,
   output lz_ptr_bins_t        ptr_len_stb
);

   logic                  trace_on;
   logic [`LZ_LEN_W-1:0]  ptr_len;
   logic                  hit;
   lz_ptr_bin_e           bin;

   assign ptr_len = sym_data[15:0];
   assign hit     = trace_on && (sym_kind == SYM_PTR) &&
                    (ptr_len >= `LZ_LEN_W'(`LZ_PTR_MIN_LEN));

   always_comb begin
      if (ptr_len >= `LZ_LEN_W'(`LZ_PTR_LEN_256)) begin
         bin = BIN_LEN_256;
      end else if (ptr_len >= `LZ_LEN_W'(`LZ_PTR_LEN_128)) begin
         bin = BIN_LEN_128;
      end else if (ptr_len >= `LZ_LEN_W'(`LZ_PTR_LEN_64)) begin
         bin = BIN_LEN_64_127;
      end else if (ptr_len >= `LZ_LEN_W'(`LZ_PTR_LEN_32)) begin
         bin = BIN_LEN_32_63;
      end else if (ptr_len >= `LZ_LEN_W'(`LZ_PTR_RANGE_LEN)) begin
         bin = BIN_LEN_11_31;
      end else begin
         bin = lz_ptr_bin_e'(ptr_len[3:0] - 4'(`LZ_PTR_MIN_LEN));   // One bin per length
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         trace_on    <= 1'b0;
         ptr_len_stb <= '0;
      end else begin
         if (pl_ep_prefix_load) begin
            trace_on <= pl_ep_trace_bit;
         end
         ptr_len_stb <= hit ? (lz_ptr_bins_t'(1) << bin) : '0;
      end
   end

endmodule

`default_nettype wire

//--- hdl/lz_frame_ctrl.sv
`default_nettype none

`include "lz_defines.svh"

module lz_frame_ctrl
   import lz_sym_pkg::*;
   import lz_stat_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire lz_sym_kind_e           sym_kind,
   input  wire logic [31:0]            sym_data,
   input  wire logic [`LZ_LEN_W-1:0]   cmd_bytes,
   input  wire logic                   offset_err,
   input  wire logic                   out_busy,
   input  wire logic                   pl_ep_prefix_load,
   input  wire logic [`LZ_POS_W-1:0]   pl_ep_prefix_cnt,
   output logic [`LZ_POS_W-1:0]        cur_pos,
   output logic                        armed,
   output logic                        frame_end,
   output logic                        ep_bm_eob,
   output logic                        ep_bm_eof,
   output lz_err_code_e                ep_bm_eof_err_code,
   output logic [`LZ_POS_W-1:0]        lz_bytes_decomp,
   output logic [`LZ_POS_W-1:0]        lz_local_bytes
);

   logic [`LZ_POS_W-1:0]   prefix_base;
   logic                   err_flag;
   logic                   eof_pend;
   logic                   eob_pend;
   logic [31:0]            eof_code;
   lz_err_code_e           final_code;

   assign frame_end = ep_bm_eof;

   // The decoder's own code wins over the overflow report
   assign final_code = (eof_code != '0) ? lz_err_code_e'(eof_code) :
                       (err_flag ? ERR_SOFT_OFLOW : ERR_NONE);

   // ########################################
   // Position and arming

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cur_pos     <= '0;
         prefix_base <= '0;
         armed       <= 1'b0;
         err_flag    <= 1'b0;
      end else begin
         if (frame_end) begin
            cur_pos     <= '0;
            prefix_base <= '0;
         end else if (pl_ep_prefix_load) begin
            cur_pos     <= pl_ep_prefix_cnt;
            prefix_base <= pl_ep_prefix_cnt;
         end else begin
            cur_pos <= cur_pos + `LZ_POS_W'(cmd_bytes);
         end

         if (sym_kind == SYM_EOF) begin
            armed <= 1'b0;
         end else if (pl_ep_prefix_load) begin
            armed <= 1'b1;
         end

         if (frame_end) begin
            err_flag <= 1'b0;
         end else if (offset_err) begin
            err_flag <= 1'b1;
         end
      end
   end

   // ########################################
   // Block and frame end, held until the command outputs drain

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         eof_pend           <= 1'b0;
         eob_pend           <= 1'b0;
         eof_code           <= '0;
         ep_bm_eof          <= 1'b0;
         ep_bm_eob          <= 1'b0;
         ep_bm_eof_err_code <= ERR_NONE;
      end else begin
         ep_bm_eof <= eof_pend && !out_busy;
         ep_bm_eob <= eob_pend && !out_busy;
         if (eof_pend && !out_busy) begin
            ep_bm_eof_err_code <= final_code;
         end

         if (sym_kind == SYM_EOF) begin
            eof_pend <= 1'b1;
            eof_code <= sym_data;
         end else if (sym_kind == SYM_EOB) begin
            eob_pend <= 1'b1;
         end else if (!out_busy) begin
            eof_pend <= 1'b0;
            eob_pend <= 1'b0;
            eof_code <= '0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lz_bytes_decomp <= '0;
         lz_local_bytes  <= '0;
      end else begin
         lz_bytes_decomp <= cur_pos;
         lz_local_bytes  <= cur_pos - prefix_base;   // Bytes since prefix load
      end
   end

   // Commands still in the pipe when the end was seen must come out before it
   a_eof_after_cmds : assert property (
      @(posedge clk) disable iff (!rst_n) ep_bm_eof |-> !out_busy);

endmodule

`default_nettype wire

//--- hdl/lz_copy_tracker.sv
`default_nettype none

`include "lz_defines.svh"

module lz_copy_tracker (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic                   copy_start,
   input  wire logic [`LZ_LEN_W-1:0]   copy_len,
   input  wire logic                   bm_ep_pause,
   input  wire logic                   frame_end,
   output logic                        copy_busy
);

   logic [`LZ_LEN_W-1:0] remain;   // Bytes of the running copy not yet moved

   // The last beat needs no stall because the next symbol can follow it directly
   assign copy_busy = (remain > `LZ_LEN_W'(`LZ_BEAT_BYTES));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remain <= '0;
      end else if (frame_end) begin
         remain <= '0;
      end else if (copy_start) begin
         remain <= copy_len;
      end else if (copy_busy && !bm_ep_pause) begin
         remain <= remain - `LZ_LEN_W'(`LZ_BEAT_BYTES);   // Frozen under pause
      end
   end

   // Symbol intake is held while busy, so no second copy can start on top
   a_no_copy_while_busy : assert property (
      @(posedge clk) disable iff (!rst_n) copy_start |-> !copy_busy);

endmodule

`default_nettype wire

//--- hdl/lz_cmd_issue.sv
`default_nettype none

`include "lz_defines.svh"

module lz_cmd_issue import lz_sym_pkg::*; (
   input  wire logic                       clk,
   input  wire logic                       rst_n,
   input  wire lz_sym_kind_e               sym_kind,
   input  wire logic [31:0]                sym_data,
   input  wire logic [2:0]                 lit_cnt,
   input  wire logic [`LZ_POS_W-1:0]       cur_pos,
   output logic                            ep_bm_lit_valid,
   output logic [2:0]                      ep_bm_num_lit,
   output logic [31:0]                     ep_bm_lit_data,
   output logic                            ep_bm_copy_valid,
   output logic [`LZ_COPY_OFF_W-1:0]       ep_bm_copy_offset,
   output logic [`LZ_LEN_W-1:0]            ep_bm_copy_length,
   output logic                            copy_start,
   output logic [`LZ_LEN_W-1:0]            copy_len,
   output logic                            offset_err,
   output logic [`LZ_LEN_W-1:0]            cmd_bytes,
   output logic                            out_busy
);

   logic [`LZ_LEN_W-1:0]        ptr_off;
   logic [`LZ_LEN_W-1:0]        ptr_len;
   logic                        is_lit;
   logic                        is_ptr;
   logic                        in_window;
   logic [`LZ_COPY_OFF_W-1:0]   copy_off;

   logic                        s1_lit_valid;
   logic [2:0]                  s1_num_lit;
   logic [31:0]                 s1_lit_data;
   logic                        s1_copy_valid;
   logic [`LZ_COPY_OFF_W-1:0]   s1_copy_off;
   logic [`LZ_LEN_W-1:0]        s1_copy_len;

   assign ptr_off = sym_data[31:16];
   assign ptr_len = sym_data[15:0];
   assign is_lit  = (sym_kind == SYM_LIT);
   assign is_ptr  = (sym_kind == SYM_PTR);

   // Must stay inside the window and inside what has been produced so far
   assign in_window = (ptr_off <= `LZ_LEN_W'(`LZ_WINDOW_BYTES)) &&
                      ({{(`LZ_POS_W-`LZ_LEN_W){1'b0}}, ptr_off} <= cur_pos);
   assign copy_off  = in_window ? ptr_off[`LZ_COPY_OFF_W-1:0] : '0;

   assign copy_start = is_ptr;
   assign copy_len   = ptr_len;
   assign offset_err = is_ptr && !in_window;
   assign cmd_bytes  = is_lit ? `LZ_LEN_W'(lit_cnt) : (is_ptr ? ptr_len : '0);
   assign out_busy   = ep_bm_lit_valid || ep_bm_copy_valid;

   // ########################################
   // Two register stages to the byte merge

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_lit_valid     <= 1'b0;
         s1_copy_valid    <= 1'b0;
         ep_bm_lit_valid  <= 1'b0;
         ep_bm_copy_valid <= 1'b0;
      end else begin
         s1_lit_valid     <= is_lit;
         s1_copy_valid    <= is_ptr;
         ep_bm_lit_valid  <= s1_lit_valid;
         ep_bm_copy_valid <= s1_copy_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (is_lit) begin
         s1_num_lit  <= lit_cnt;
         s1_lit_data <= sym_data;
      end
      if (is_ptr) begin
         s1_copy_off <= copy_off;
         s1_copy_len <= ptr_len;
      end
      if (s1_lit_valid) begin
         ep_bm_num_lit  <= s1_num_lit;
         ep_bm_lit_data <= s1_lit_data;
      end
      if (s1_copy_valid) begin
         ep_bm_copy_offset <= s1_copy_off;
         ep_bm_copy_length <= s1_copy_len;
      end
   end

   a_one_cmd_per_cycle : assert property (
      @(posedge clk) disable iff (!rst_n) !(ep_bm_lit_valid && ep_bm_copy_valid));

endmodule

`default_nettype wire

//--- hdl/lz_sym_holder.sv
`default_nettype none

module lz_sym_holder import lz_sym_pkg::*; (
   input  wire logic         clk,
   input  wire logic         rst_n,
   input  wire lz_sym_t      if_ep_sym,
   input  wire logic         if_ep_sym_valid,
   input  wire logic         bm_ep_pause,
   input  wire logic         copy_busy,
   input  wire logic         armed,
   input  wire logic         frame_end,
   output lz_sym_kind_e      sym_kind,
   output logic [31:0]       sym_data,
   output logic [2:0]        lit_cnt,
   output logic              ep_if_entry_done
);

   lz_sym_t   held_sym;
   logic      held_valid;
   lz_sym_t   cand_sym;
   logic      cand_valid;
   logic      stall;
   logic      take;
   logic      park;

   assign stall      = bm_ep_pause || copy_busy;
   assign cand_valid = held_valid || if_ep_sym_valid;
   assign cand_sym   = held_valid ? held_sym : if_ep_sym;   // Parked symbol goes first
   assign take       = cand_valid && armed && !stall;
   assign park       = cand_valid && armed && stall && !frame_end;

   // Class decode of the accepted symbol with the literal first
   always_comb begin
      sym_kind = SYM_NONE;
      sym_data = '0;
      lit_cnt  = '0;
      if (take) begin
         sym_data = cand_sym.data;
         if (cand_sym.lit_valid) begin
            sym_kind = SYM_LIT;
            lit_cnt  = cand_sym.lit_cnt;
         end else if (cand_sym.ptr_valid) begin
            sym_kind = SYM_PTR;
         end else if (cand_sym.eof_valid) begin
            sym_kind = SYM_EOF;
         end else if (cand_sym.eob_valid) begin
            sym_kind = SYM_EOB;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         held_valid       <= 1'b0;
         ep_if_entry_done <= 1'b0;
      end else begin
         held_valid       <= park;
         // No request for more input while a block or frame end drains
         ep_if_entry_done <= armed && !stall &&
                             (sym_kind != SYM_EOF) && (sym_kind != SYM_EOB);
      end
   end

   always_ff @(posedge clk) begin
      if (park) begin
         held_sym <= cand_sym;
      end
   end

   // The source waits for entry done, so nothing new shows up on top of a parked symbol
   a_no_sym_while_parked : assert property (
      @(posedge clk) disable iff (!rst_n) held_valid |-> !if_ep_sym_valid);

endmodule

`default_nettype wire

//--- hdl/lz_stat_pkg.sv
`default_nettype none

`include "lz_defines.svh"

package lz_stat_pkg;

   typedef enum logic [31:0] {
      ERR_NONE       = 32'h0000_0000,
      ERR_SOFT_OFLOW = 32'h0000_0023   // Pointer reached outside the local window
   } lz_err_code_e;

   typedef enum logic [3:0] {
      BIN_LEN_3      = 4'd0,
      BIN_LEN_4      = 4'd1,
      BIN_LEN_5      = 4'd2,
      BIN_LEN_6      = 4'd3,
      BIN_LEN_7      = 4'd4,
      BIN_LEN_8      = 4'd5,
      BIN_LEN_9      = 4'd6,
      BIN_LEN_10     = 4'd7,
      BIN_LEN_11_31  = 4'd8,
      BIN_LEN_32_63  = 4'd9,
      BIN_LEN_64_127 = 4'd10,
      BIN_LEN_128    = 4'd11,
      BIN_LEN_256    = 4'd12
   } lz_ptr_bin_e;

   typedef logic [`LZ_PTR_BIN_COUNT-1:0] lz_ptr_bins_t;

endpackage

`default_nettype wire

//--- hdl/lz_sym_pkg.sv
`default_nettype none

package lz_sym_pkg;

   // Symbol as delivered by the decoder
   // A pointer carries its offset in data[31:16] and its length in data[15:0]
   typedef struct packed {
      logic        lit_valid;
      logic        ptr_valid;
      logic        eof_valid;
      logic        eob_valid;
      logic        rsvd;
      logic [2:0]  lit_cnt;     // 1 to 4 bytes
      logic [31:0] data;
   } lz_sym_t;

   typedef enum logic [2:0] {
      SYM_NONE = 3'd0,
      SYM_LIT  = 3'd1,
      SYM_PTR  = 3'd2,
      SYM_EOF  = 3'd3,
      SYM_EOB  = 3'd4
   } lz_sym_kind_e;

endpackage

`default_nettype wire

//--- hdl/lz_defines.svh
`ifndef LZ_DEFINES_SVH
`define LZ_DEFINES_SVH

// Reach of a copy without a history read, and bytes the copy engine moves per beat
`define LZ_WINDOW_BYTES   16
`define LZ_BEAT_BYTES     16

`define LZ_POS_W          17
`define LZ_LEN_W          16
`define LZ_COPY_OFF_W     5

// ########################################
// Pointer length histogram
`define LZ_PTR_BIN_COUNT  13
`define LZ_PTR_MIN_LEN    3
`define LZ_PTR_RANGE_LEN  11   // First length that falls into a range bin
`define LZ_PTR_LEN_32     32
`define LZ_PTR_LEN_64     64
`define LZ_PTR_LEN_128    128
`define LZ_PTR_LEN_256    256

`endif
